// File: mem_stage_pkg.sv
package mem_stage_pkg;

    // architectural data width, also the width of addresses and counts
    localparam int DATA_W = 32;

    // operand size of a memory access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } opsize_t;

    // operand source codes
    typedef enum logic [2:0] {
        SRC_REG1 = 3'd0,
        SRC_REG2 = 3'd1,
        SRC_MEM1 = 3'd2,
        SRC_MEM2 = 3'd3,
        SRC_IMM  = 3'd4,
        SRC_EIP  = 3'd5
    } src_sel_t;

    // destination codes
    typedef enum logic [1:0] {
        DST_REG1 = 2'd0,
        DST_REG2 = 2'd1,
        DST_MEM1 = 2'd2,
        DST_MEM2 = 2'd3
    } dst_sel_t;

    // bytes per access, used as the REP address step
    function automatic logic [DATA_W-1:0] size_bytes(input opsize_t size);
        case (size)
            SIZE_BYTE: return DATA_W'(1);
            SIZE_HALF: return DATA_W'(2);
            default:   return DATA_W'(4);
        endcase
    endfunction

endpackage

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                               clk,
    input  logic                               en,
    input  logic                               we,
    input  logic [RAM_ADDR_BITS-1:0]           addr,
    input  logic [mem_stage_pkg::DATA_W-1:0]   wdata,
    output logic [mem_stage_pkg::DATA_W-1:0]   rdata
);

    logic [mem_stage_pkg::DATA_W-1:0] mem [2**RAM_ADDR_BITS];

    // single port, a write cycle leaves rdata unchanged
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: dmem_arbiter.sv
`timescale 1ns/1ps

module dmem_arbiter #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               req1,
    input  logic [mem_stage_pkg::DATA_W-1:0]   req_addr1,
    input  logic                               req2,
    input  logic [mem_stage_pkg::DATA_W-1:0]   req_addr2,
    input  logic                               wb_valid,
    input  logic [mem_stage_pkg::DATA_W-1:0]   wb_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0]   wb_data,
    output logic                               grant1,
    output logic                               grant2,
    output logic                               rd_valid1,
    output logic                               rd_valid2,
    output logic                               ram_en,
    output logic                               ram_we,
    output logic [RAM_ADDR_BITS-1:0]           ram_addr,
    output logic [mem_stage_pkg::DATA_W-1:0]   ram_wdata
);

    logic                       wb_pend;
    logic                       prio2;
    logic [RAM_ADDR_BITS-1:0]   wb_addr_q;

    // buffered write goes first, reads alternate
    assign grant1    = !wb_pend && req1 && (!req2 || !prio2);
    assign grant2    = !wb_pend && req2 && (!req1 || prio2);
    assign ram_en    = wb_pend || grant1 || grant2;
    assign ram_we    = wb_pend;
    assign ram_addr  = wb_pend ? wb_addr_q :
                       grant2  ? req_addr2[RAM_ADDR_BITS-1:0] : req_addr1[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_pend   <= 1'b0;
            prio2     <= 1'b0;
            rd_valid1 <= 1'b0;
            rd_valid2 <= 1'b0;
        end else begin
            // the pending write always drains the next cycle
            wb_pend   <= wb_valid;
            rd_valid1 <= grant1;
            rd_valid2 <= grant2;
            if (grant1) begin
                prio2 <= 1'b1;
            end else if (grant2) begin
                prio2 <= 1'b0;
            end
        end
    end

    // wb_addr is a byte address
    always_ff @(posedge clk) begin
        if (wb_valid) begin
            wb_addr_q <= wb_addr[RAM_ADDR_BITS+1:2];
            ram_wdata <= wb_data;
        end
    end

    // a refused request stays up until it is granted
    assert property (@(posedge clk) disable iff (!rst_n) (req1 && !grant1) |=> req1);
    assert property (@(posedge clk) disable iff (!rst_n) (req2 && !grant2) |=> req2);
    assert property (@(posedge clk) disable iff (!rst_n) wb_valid |=> !wb_valid);

endmodule

// File: mem_operand_port.sv
`timescale 1ns/1ps

module mem_operand_port (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic                               en,
    input  logic [mem_stage_pkg::DATA_W-1:0]   addr,
    input  mem_stage_pkg::opsize_t             size,
    input  logic                               grant,
    input  logic                               rd_valid,
    input  logic [mem_stage_pkg::DATA_W-1:0]   rd_data,
    output logic                               req,
    output logic [mem_stage_pkg::DATA_W-1:0]   req_addr,
    output logic                               done,
    output logic [mem_stage_pkg::DATA_W-1:0]   data
);

    logic                               pend;
    logic [1:0]                         lane;
    logic [mem_stage_pkg::DATA_W-3:0]   word_addr;
    mem_stage_pkg::opsize_t             size_q;
    logic [mem_stage_pkg::DATA_W-1:0]   word_q;

    // request goes out in the start cycle already, then holds until granted
    assign req      = (start && en) || pend;
    assign req_addr = start ? {2'b00, addr[mem_stage_pkg::DATA_W-1:2]} : {2'b00, word_addr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            pend <= en && !grant;
            done <= 1'b0;
        end else begin
            if (grant) begin
                pend <= 1'b0;
            end
            if (rd_valid) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            word_addr <= addr[mem_stage_pkg::DATA_W-1:2];
            lane      <= addr[1:0];
            size_q    <= size;
        end
        if (rd_valid) begin
            word_q <= rd_data;
        end
    end

    // little-endian lane pick, zero extended
    always_comb begin
        case (size_q)
            mem_stage_pkg::SIZE_BYTE: data = {24'h0, word_q[{lane, 3'b000} +: 8]};
            mem_stage_pkg::SIZE_HALF: data = {16'h0, word_q[{lane[1], 4'b0000} +: 16]};
            default:                  data = word_q;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (start && en) |-> (size == mem_stage_pkg::SIZE_BYTE) ||
                          (size == mem_stage_pkg::SIZE_HALF && !addr[0]) ||
                          (addr[1:0] == 2'b00));

endmodule

// File: rep_addr_gen.sv
`timescale 1ns/1ps

module rep_addr_gen (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               valid_in,
    input  logic [mem_stage_pkg::DATA_W-1:0]   mem_addr1,
    input  logic [mem_stage_pkg::DATA_W-1:0]   mem_addr2,
    input  mem_stage_pkg::opsize_t             opsize,
    input  logic                               is_rep,
    input  logic                               dir_down,
    input  logic [mem_stage_pkg::DATA_W-1:0]   rep_count,
    input  logic                               rd1_en_in,
    input  logic                               rd2_en_in,
    input  logic                               done1,
    input  logic                               done2,
    output logic                               iter_start,
    output logic [mem_stage_pkg::DATA_W-1:0]   iter_addr1,
    output logic [mem_stage_pkg::DATA_W-1:0]   iter_addr2,
    output mem_stage_pkg::opsize_t             iter_size,
    output logic                               rd1_en,
    output logic                               rd2_en,
    output logic                               iter_done,
    output logic                               stall
);

    // START issues the reads, WAIT collects them, DRAIN covers the valid_out cycle
    typedef enum logic [1:0] {S_IDLE, S_START, S_WAIT, S_DRAIN} state_t;

    state_t                             state;
    logic [mem_stage_pkg::DATA_W-1:0]   count;
    logic [mem_stage_pkg::DATA_W-1:0]   step;
    logic                               dir_q;
    logic                               all_done;

    assign step       = mem_stage_pkg::size_bytes(iter_size);
    // a disabled port counts as done
    assign all_done   = (done1 || !rd1_en) && (done2 || !rd2_en);
    assign iter_start = (state == S_START);
    assign iter_done  = (state == S_WAIT) && all_done;
    assign stall      = (state != S_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            count <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (valid_in) begin
                        // non-REP runs exactly once
                        count <= is_rep ? rep_count : mem_stage_pkg::DATA_W'(1);
                        state <= (is_rep && rep_count == '0) ? S_DRAIN : S_START;
                    end
                end
                S_START: state <= S_WAIT;
                S_WAIT: begin
                    if (all_done) begin
                        count <= count - 1'b1;
                        state <= (count == mem_stage_pkg::DATA_W'(1)) ? S_DRAIN : S_START;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // instruction payload and address stepping
    always_ff @(posedge clk) begin
        if (state == S_IDLE && valid_in) begin
            iter_addr1 <= mem_addr1;
            iter_addr2 <= mem_addr2;
            iter_size  <= opsize;
            dir_q      <= dir_down;
            rd1_en     <= rd1_en_in;
            rd2_en     <= rd2_en_in;
        end else if (iter_done) begin
            iter_addr1 <= dir_q ? iter_addr1 - step : iter_addr1 + step;
            iter_addr2 <= dir_q ? iter_addr2 - step : iter_addr2 + step;
        end
    end

    // upstream holds off while the stage is busy
    assert property (@(posedge clk) disable iff (!rst_n) stall |-> !valid_in);

endmodule

// File: operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  logic                               capture,
    input  mem_stage_pkg::src_sel_t            op1_sel,
    input  mem_stage_pkg::src_sel_t            op2_sel,
    input  mem_stage_pkg::dst_sel_t            dest_sel,
    input  logic [mem_stage_pkg::DATA_W-1:0]   reg1,
    input  logic [mem_stage_pkg::DATA_W-1:0]   reg2,
    input  logic [mem_stage_pkg::DATA_W-1:0]   imm,
    input  logic [mem_stage_pkg::DATA_W-1:0]   eip,
    input  logic [mem_stage_pkg::DATA_W-1:0]   mem1_data,
    input  logic [mem_stage_pkg::DATA_W-1:0]   mem2_data,
    input  logic [mem_stage_pkg::DATA_W-1:0]   addr1,
    input  logic [mem_stage_pkg::DATA_W-1:0]   addr2,
    output logic                               valid_out,
    output logic [mem_stage_pkg::DATA_W-1:0]   op1_val,
    output logic [mem_stage_pkg::DATA_W-1:0]   op2_val,
    output logic [mem_stage_pkg::DATA_W-1:0]   dest_addr,
    output logic                               dest_is_reg,
    output logic                               dest_is_mem
);

    mem_stage_pkg::src_sel_t            op1_sel_q;
    mem_stage_pkg::src_sel_t            op2_sel_q;
    mem_stage_pkg::dst_sel_t            dest_sel_q;
    logic [mem_stage_pkg::DATA_W-1:0]   reg1_q;
    logic [mem_stage_pkg::DATA_W-1:0]   reg2_q;
    logic [mem_stage_pkg::DATA_W-1:0]   imm_q;
    logic [mem_stage_pkg::DATA_W-1:0]   eip_q;

    function automatic logic [mem_stage_pkg::DATA_W-1:0] pick(
        input mem_stage_pkg::src_sel_t sel
    );
        case (sel)
            mem_stage_pkg::SRC_REG1: return reg1_q;
            mem_stage_pkg::SRC_REG2: return reg2_q;
            mem_stage_pkg::SRC_MEM1: return mem1_data;
            mem_stage_pkg::SRC_MEM2: return mem2_data;
            mem_stage_pkg::SRC_IMM:  return imm_q;
            default:                 return eip_q;
        endcase
    endfunction

    // instruction fields stay put for all REP iterations
    always_ff @(posedge clk) begin
        if (load) begin
            op1_sel_q  <= op1_sel;
            op2_sel_q  <= op2_sel;
            dest_sel_q <= dest_sel;
            reg1_q     <= reg1;
            reg2_q     <= reg2;
            imm_q      <= imm;
            eip_q      <= eip;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= capture;
        end
    end

    // register destinations report register number 1 or 2
    always_ff @(posedge clk) begin
        if (capture) begin
            op1_val     <= pick(op1_sel_q);
            op2_val     <= pick(op2_sel_q);
            dest_is_reg <= !dest_sel_q[1];
            dest_is_mem <= dest_sel_q[1];
            case (dest_sel_q)
                mem_stage_pkg::DST_REG1: dest_addr <= mem_stage_pkg::DATA_W'(1);
                mem_stage_pkg::DST_REG2: dest_addr <= mem_stage_pkg::DATA_W'(2);
                mem_stage_pkg::DST_MEM1: dest_addr <= addr1;
                default:                 dest_addr <= addr2;
            endcase
        end
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               valid_in,
    input  logic [mem_stage_pkg::DATA_W-1:0]   mem_addr1,
    input  logic [mem_stage_pkg::DATA_W-1:0]   mem_addr2,
    input  mem_stage_pkg::opsize_t             opsize,
    input  logic                               is_rep,
    input  logic                               dir_down,
    input  logic [mem_stage_pkg::DATA_W-1:0]   rep_count,
    input  logic                               rd1_en,
    input  logic                               rd2_en,
    input  mem_stage_pkg::src_sel_t            op1_sel,
    input  mem_stage_pkg::src_sel_t            op2_sel,
    input  mem_stage_pkg::dst_sel_t            dest_sel,
    input  logic [mem_stage_pkg::DATA_W-1:0]   reg1,
    input  logic [mem_stage_pkg::DATA_W-1:0]   reg2,
    input  logic [mem_stage_pkg::DATA_W-1:0]   imm,
    input  logic [mem_stage_pkg::DATA_W-1:0]   eip,
    input  logic                               wb_valid,
    input  logic [mem_stage_pkg::DATA_W-1:0]   wb_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0]   wb_data,
    output logic                               stall,
    output logic                               valid_out,
    output logic [mem_stage_pkg::DATA_W-1:0]   op1_val,
    output logic [mem_stage_pkg::DATA_W-1:0]   op2_val,
    output logic [mem_stage_pkg::DATA_W-1:0]   dest_addr,
    output logic                               dest_is_reg,
    output logic                               dest_is_mem
);

    logic                               iter_start, iter_done, seq_rd1_en, seq_rd2_en;
    logic                               done1, done2, req1, req2, grant1, grant2;
    logic                               rd_valid1, rd_valid2, ram_en, ram_we;
    logic [mem_stage_pkg::DATA_W-1:0]   iter_addr1, iter_addr2, req_addr1, req_addr2;
    logic [mem_stage_pkg::DATA_W-1:0]   mem1_data, mem2_data, ram_wdata, ram_rdata;
    logic [RAM_ADDR_BITS-1:0]           ram_addr;
    mem_stage_pkg::opsize_t             iter_size;

    rep_addr_gen rep_addr_gen_inst (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in),
        .mem_addr1(mem_addr1), .mem_addr2(mem_addr2), .opsize(opsize),
        .is_rep(is_rep), .dir_down(dir_down), .rep_count(rep_count),
        .rd1_en_in(rd1_en), .rd2_en_in(rd2_en), .done1(done1), .done2(done2),
        .iter_start(iter_start), .iter_addr1(iter_addr1), .iter_addr2(iter_addr2),
        .iter_size(iter_size), .rd1_en(seq_rd1_en), .rd2_en(seq_rd2_en),
        .iter_done(iter_done), .stall(stall)
    );

    mem_operand_port port1_inst (
        .clk(clk), .rst_n(rst_n), .start(iter_start), .en(seq_rd1_en),
        .addr(iter_addr1), .size(iter_size), .grant(grant1),
        .rd_valid(rd_valid1), .rd_data(ram_rdata),
        .req(req1), .req_addr(req_addr1), .done(done1), .data(mem1_data)
    );

    mem_operand_port port2_inst (
        .clk(clk), .rst_n(rst_n), .start(iter_start), .en(seq_rd2_en),
        .addr(iter_addr2), .size(iter_size), .grant(grant2),
        .rd_valid(rd_valid2), .rd_data(ram_rdata),
        .req(req2), .req_addr(req_addr2), .done(done2), .data(mem2_data)
    );

    dmem_arbiter #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) dmem_arbiter_inst (
        .clk(clk), .rst_n(rst_n),
        .req1(req1), .req_addr1(req_addr1), .req2(req2), .req_addr2(req_addr2),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
        .grant1(grant1), .grant2(grant2), .rd_valid1(rd_valid1), .rd_valid2(rd_valid2),
        .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
    );

    data_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) data_ram_inst (
        .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    // select fields load in the same cycle the sequencer latches the instruction
    operand_select operand_select_inst (
        .clk(clk), .rst_n(rst_n), .load(valid_in), .capture(iter_done),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .dest_sel(dest_sel),
        .reg1(reg1), .reg2(reg2), .imm(imm), .eip(eip),
        .mem1_data(mem1_data), .mem2_data(mem2_data),
        .addr1(iter_addr1), .addr2(iter_addr2),
        .valid_out(valid_out), .op1_val(op1_val), .op2_val(op2_val),
        .dest_addr(dest_addr), .dest_is_reg(dest_is_reg), .dest_is_mem(dest_is_mem)
    );

endmodule

// File: mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    logic                               clk;
    logic                               rst_n;
    logic                               valid_in;
    logic [mem_stage_pkg::DATA_W-1:0]   mem_addr1;
    logic [mem_stage_pkg::DATA_W-1:0]   mem_addr2;
    mem_stage_pkg::opsize_t             opsize;
    logic                               is_rep;
    logic                               dir_down;
    logic [mem_stage_pkg::DATA_W-1:0]   rep_count;
    logic                               rd1_en;
    logic                               rd2_en;
    mem_stage_pkg::src_sel_t            op1_sel;
    mem_stage_pkg::src_sel_t            op2_sel;
    mem_stage_pkg::dst_sel_t            dest_sel;
    logic [mem_stage_pkg::DATA_W-1:0]   reg1;
    logic [mem_stage_pkg::DATA_W-1:0]   reg2;
    logic [mem_stage_pkg::DATA_W-1:0]   imm;
    logic [mem_stage_pkg::DATA_W-1:0]   eip;
    logic                               wb_valid;
    logic [mem_stage_pkg::DATA_W-1:0]   wb_addr;
    logic [mem_stage_pkg::DATA_W-1:0]   wb_data;
    logic                               stall;
    logic                               valid_out;
    logic [mem_stage_pkg::DATA_W-1:0]   op1_val;
    logic [mem_stage_pkg::DATA_W-1:0]   op2_val;
    logic [mem_stage_pkg::DATA_W-1:0]   dest_addr;
    logic                               dest_is_reg;
    logic                               dest_is_mem;

    // word-addressed reference copy of the RAM
    logic [31:0] model [logic [31:0]];
    int          errors;
    int          checks;
    int          instr_no;
    int          seed;
    bit          abort;
    int          fd;

    mem_stage #(.RAM_ADDR_BITS(8)) mem_stage_inst (
        .clk(clk), .rst_n(rst_n), .valid_in(valid_in),
        .mem_addr1(mem_addr1), .mem_addr2(mem_addr2), .opsize(opsize),
        .is_rep(is_rep), .dir_down(dir_down), .rep_count(rep_count),
        .rd1_en(rd1_en), .rd2_en(rd2_en),
        .op1_sel(op1_sel), .op2_sel(op2_sel), .dest_sel(dest_sel),
        .reg1(reg1), .reg2(reg2), .imm(imm), .eip(eip),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
        .stall(stall), .valid_out(valid_out), .op1_val(op1_val), .op2_val(op2_val),
        .dest_addr(dest_addr), .dest_is_reg(dest_is_reg), .dest_is_mem(dest_is_mem)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // zero-extended byte, halfword or word at a byte address
    function automatic logic [31:0] model_lane(input logic [31:0] addr, input logic [1:0] size);
        logic [31:0] w;
        w = model.exists(addr >> 2) ? model[addr >> 2] : 32'h0;
        w = w >> (addr[1:0] * 8);
        case (size)
            2'd0:    return w & 32'h0000_00ff;
            2'd1:    return w & 32'h0000_ffff;
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic wait_valid_out();
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!valid_out && t < 100);
        if (!valid_out) begin
            errors++;
            abort = 1'b1;
            $display("instruction %0d never produced valid_out", instr_no);
        end
    endtask

    task automatic wait_stall_low(input bit forbid_valid);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (forbid_valid) begin
                checks++;
                assert (!valid_out) else begin
                    errors++;
                    $display("instruction %0d gave valid_out with a zero count", instr_no);
                end
            end
        end while (stall && t < 100);
        if (stall) begin
            errors++;
            abort = 1'b1;
            $display("stall stayed high after instruction %0d", instr_no);
        end
    endtask

    task automatic drive_writeback(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_addr  <= addr;
        wb_data  <= data;
        model[addr >> 2] = data;
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic run_instruction();
        logic [31:0] a1, a2, sz, rep, dn, cnt, e1, e2, s1, s2, ds, r1, r2, im, ip;
        logic [31:0] wbf, wba, wbd, n, x1, x2, xd, xr, xm, step;
        logic [8*8-1:0] tag;
        int i;
        string name;
        void'($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      a1, a2, sz, rep, dn, cnt, e1, e2, s1, s2, ds, r1, r2, im, ip,
                      wbf, wba, wbd, n));
        instr_no++;
        @(posedge clk);
        valid_in  <= 1'b1;
        mem_addr1 <= a1;
        mem_addr2 <= a2;
        opsize    <= mem_stage_pkg::opsize_t'(sz[1:0]);
        is_rep    <= rep[0];
        dir_down  <= dn[0];
        rep_count <= cnt;
        rd1_en    <= e1[0];
        rd2_en    <= e2[0];
        op1_sel   <= mem_stage_pkg::src_sel_t'(s1[2:0]);
        op2_sel   <= mem_stage_pkg::src_sel_t'(s2[2:0]);
        dest_sel  <= mem_stage_pkg::dst_sel_t'(ds[1:0]);
        reg1      <= r1;
        reg2      <= r2;
        imm       <= im;
        eip       <= ip;
        @(posedge clk);
        valid_in <= 1'b0;
        // optional write-back racing the reads
        if (wbf[0]) begin
            wb_valid <= 1'b1;
            wb_addr  <= wba;
            wb_data  <= wbd;
            model[wba >> 2] = wbd;
        end
        @(posedge clk);
        wb_valid <= 1'b0;
        step = (sz == 0) ? 32'd1 : (sz == 1) ? 32'd2 : 32'd4;
        for (i = 0; i < n && !abort; i++) begin
            void'($fscanf(fd, " %s %h %h %h %h %h", tag, x1, x2, xd, xr, xm));
            wait_valid_out();
            if (!abort) begin
                name = $sformatf("instr%0d iter%0d", instr_no, i);
                check_value({name, " op1"}, x1, op1_val);
                check_value({name, " op2"}, x2, op2_val);
                check_value({name, " dest_addr"}, xd, dest_addr);
                check_value({name, " dest_is_reg"}, xr, {31'h0, dest_is_reg});
                check_value({name, " dest_is_mem"}, xm, {31'h0, dest_is_mem});
                check_value({name, " stall"}, 32'h1, {31'h0, stall});
                if (s1 == 2) begin
                    check_value({name, " op1 model"}, model_lane(a1, sz[1:0]), op1_val);
                end
                if (s2 == 3) begin
                    check_value({name, " op2 model"}, model_lane(a2, sz[1:0]), op2_val);
                end
                a1 = dn[0] ? a1 - step : a1 + step;
                a2 = dn[0] ? a2 - step : a2 + step;
            end
        end
        if (!abort) begin
            wait_stall_low(n == 0);
        end
    endtask

    initial begin
        logic [8*8-1:0]   tag;
        logic [8*200-1:0] line;
        logic [31:0]      wa, wd;
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        mem_addr1 = '0;
        mem_addr2 = '0;
        opsize    = mem_stage_pkg::SIZE_WORD;
        is_rep    = 1'b0;
        dir_down  = 1'b0;
        rep_count = '0;
        rd1_en    = 1'b0;
        rd2_en    = 1'b0;
        op1_sel   = mem_stage_pkg::SRC_REG1;
        op2_sel   = mem_stage_pkg::SRC_REG1;
        dest_sel  = mem_stage_pkg::DST_REG1;
        reg1      = '0;
        reg2      = '0;
        imm       = '0;
        eip       = '0;
        wb_valid  = 1'b0;
        wb_addr   = '0;
        wb_data   = '0;
        errors    = 0;
        checks    = 0;
        instr_no  = 0;
        abort     = 1'b0;
        seed      = 32'h425aaabe;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset stall", 32'h0, {31'h0, stall});
        check_value("reset valid_out", 32'h0, {31'h0, valid_out});
        fd = $fopen("mem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end else begin
            while (!abort && $fscanf(fd, " %s", tag) == 1) begin
                if (tag == "#") begin
                    void'($fgets(line, fd));
                end else if (tag == "W") begin
                    void'($fscanf(fd, "%h %h", wa, wd));
                    drive_writeback(wa, wd);
                end else if (tag == "I") begin
                    run_instruction();
                    repeat ($unsigned($random(seed)) % 3) @(posedge clk);
                end else begin
                    errors++;
                    abort = 1'b1;
                    $display("unknown record in the stimulus file");
                end
            end
            $fclose(fd);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mem_stage_stimulus.txt
# W byte_addr data
# I a1 a2 size rep dir count rd1 rd2 op1_sel op2_sel dest_sel reg1 reg2 imm eip wb wb_addr wb_data n
# E op1 op2 dest_addr dest_is_reg dest_is_mem  (n lines after each I)
W 10 11223344
W 14 55667788
W 18 99aabbcc
W 1c deadbeef
W 20 cafef00d
W 40 01020304
# single word read into op1
I 10 0 2 0 0 0 1 0 2 0 0 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 11223344 aaaa0001 1 1 0
# two ports through the arbiter
I 14 18 2 0 0 0 1 1 2 3 2 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 55667788 99aabbcc 14 0 1
# register, immediate and eip sources
I 0 0 2 0 0 0 0 0 4 5 1 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 12345678 00400000 2 1 0
I 0 1c 2 0 0 0 0 0 1 0 3 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E bbbb0002 aaaa0001 1c 0 1
# byte and halfword lanes
I 1d 0 0 0 0 0 1 0 2 4 0 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 000000be 12345678 1 1 0
I 0 22 1 0 0 0 0 1 3 1 2 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 0000cafe bbbb0002 0 0 1
# REP up, down, byte steps and zero count
I 10 18 2 1 0 3 1 1 2 3 2 aaaa0001 bbbb0002 12345678 00400000 0 0 0 3
E 11223344 99aabbcc 10 0 1
E 55667788 deadbeef 14 0 1
E 99aabbcc cafef00d 18 0 1
I 22 0 1 1 1 2 1 0 2 4 2 aaaa0001 bbbb0002 12345678 00400000 0 0 0 2
E 0000cafe 12345678 22 0 1
E 0000f00d 12345678 20 0 1
I 40 0 0 1 0 4 1 0 2 0 2 aaaa0001 bbbb0002 12345678 00400000 0 0 0 4
E 00000004 aaaa0001 40 0 1
E 00000003 aaaa0001 41 0 1
E 00000002 aaaa0001 42 0 1
E 00000001 aaaa0001 43 0 1
I 10 14 2 1 0 0 1 1 2 3 2 aaaa0001 bbbb0002 12345678 00400000 0 0 0 0
# write-back during reads, then read it back
I 10 14 2 0 0 0 1 1 2 3 0 aaaa0001 bbbb0002 12345678 00400000 1 30 13572468 1
E 11223344 55667788 1 1 0
I 30 0 2 0 0 0 1 0 2 0 0 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 13572468 aaaa0001 1 1 0
W 10 0badf00d
I 10 1c 2 0 0 0 1 1 2 3 0 aaaa0001 bbbb0002 12345678 00400000 0 0 0 1
E 0badf00d deadbeef 1 1 0

// File: mem_stage.f
mem_stage_pkg.sv
data_ram.sv
dmem_arbiter.sv
mem_operand_port.sv
rep_addr_gen.sv
operand_select.sv
mem_stage.sv
mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - mem_stage_pkg.sv
  - data_ram.sv
  - dmem_arbiter.sv
  - mem_operand_port.sv
  - rep_addr_gen.sv
  - operand_select.sv
  - mem_stage.sv
  - target: simulation
    files:
      - mem_stage_tb.sv
